/* src/bus_params.svh */
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Narrow stream word width in bits
`define BUS_NARROW_W 32

// Register stages in the wide pipe
`define BUS_PIPE_STAGES 4

// Half order of the wide word
// 0 puts the first narrow word low, 1 puts it high
`define BUS_BIGENDIAN 1'b0

`endif

/* src/bus_pkg.sv */
`default_nettype none

`include "bus_params.svh"

package bus_pkg;

    // ==============================
    // Data words
    // ==============================
    typedef logic [`BUS_NARROW_W-1:0]   narrow_t;
    // Wide word holds exactly two narrow words
    typedef logic [2*`BUS_NARROW_W-1:0] wide_t;

    // ==============================
    // Forward bus signals
    // ==============================
    // rdy runs the other way, kept outside the structs
    typedef struct packed {
        logic    valid;
        narrow_t data;
    } narrow_fwd_t;

    typedef struct packed {
        logic  valid;
        wide_t data;
    } wide_fwd_t;

endpackage

`default_nettype wire

/* src/bus_width_up.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_width_up #(
    parameter bit BIGENDIAN = 1'b0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  bus_pkg::narrow_fwd_t  in_fwd,
    output logic                  in_rdy,
    output bus_pkg::wide_fwd_t    out_fwd,
    input  logic                  out_rdy
);

    // ==============================
    // State
    // ==============================
    // First word of the current pair
    bus_pkg::narrow_t half_d;
    // High while a first word waits in half_d
    logic             phase;
    // Packed wide output register
    logic             out_v;
    bus_pkg::wide_t   out_d;

    logic             in_acc;
    logic             out_acc;
    logic             pair_done;

    // ==============================
    // Handshake
    // ==============================
    // Room when output empty or leaving this cycle
    assign in_rdy    = !out_v || out_rdy;
    assign in_acc    = in_fwd.valid && in_rdy;
    assign out_acc   = out_v && out_rdy;
    // Second word of a pair arrives
    assign pair_done = in_acc && phase;

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= 1'b0;
            out_v <= 1'b0;
        end else begin
            // Toggle on every accepted narrow word
            if (in_acc) begin
                phase <= !phase;
            end
            // Fill beats drain when both happen together
            if (pair_done) begin
                out_v <= 1'b1;
            end else if (out_acc) begin
                out_v <= 1'b0;
            end
        end
    end

    // ==============================
    // Data path
    // ==============================
    always_ff @(posedge clk) begin
        // Park the first word
        if (in_acc && !phase) begin
            half_d <= in_fwd.data;
        end
        // Join the pair, first word in the half set by BIGENDIAN
        if (pair_done) begin
            if (BIGENDIAN) begin
                out_d <= {half_d, in_fwd.data};
            end else begin
                out_d <= {in_fwd.data, half_d};
            end
        end
    end

    assign out_fwd = '{valid: out_v, data: out_d};

endmodule

`default_nettype wire

/* src/bus_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_pipe #(
    parameter int unsigned STAGES = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  bus_pkg::wide_fwd_t  in_fwd,
    output logic                in_rdy,
    output bus_pkg::wide_fwd_t  out_fwd,
    input  logic                out_rdy
);

    // ==============================
    // Stage links
    // ==============================
    // Link i feeds stage i, link STAGES is the pipe output
    bus_pkg::wide_fwd_t link_fwd [STAGES+1];
    logic               link_rdy [STAGES+1];

    assign link_fwd[0]      = in_fwd;
    assign in_rdy           = link_rdy[0];
    assign out_fwd          = link_fwd[STAGES];
    assign link_rdy[STAGES] = out_rdy;

    // ==============================
    // Skid stages
    // ==============================
    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        // Main register drives the next link
        logic           main_v;
        bus_pkg::wide_t main_d;
        // Skid register catches the word in flight when downstream stalls
        logic           skid_v;
        bus_pkg::wide_t skid_d;

        logic           load_main;
        logic           load_skid;

        // Main free or draining this cycle
        assign load_main = !main_v || link_rdy[i+1];
        // Main stuck, incoming word goes to skid
        assign load_skid = !load_main && link_fwd[i].valid && !skid_v;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                main_v <= 1'b0;
                skid_v <= 1'b0;
            end else begin
                if (load_main) begin
                    // Skid first, it holds the older word
                    main_v <= skid_v || link_fwd[i].valid;
                    skid_v <= 1'b0;
                end else if (load_skid) begin
                    skid_v <= 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (load_main) begin
                main_d <= skid_v ? skid_d : link_fwd[i].data;
            end
            if (load_skid) begin
                skid_d <= link_fwd[i].data;
            end
        end

        // Upstream rdy comes straight off the skid flop
        // Full skid means no slot left for a word in flight
        assign link_rdy[i]   = !skid_v;
        assign link_fwd[i+1] = '{valid: main_v, data: main_d};
    end

endmodule

`default_nettype wire

/* src/bus_width_down.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_width_down #(
    parameter bit BIGENDIAN = 1'b0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  bus_pkg::wide_fwd_t    in_fwd,
    output logic                  in_rdy,
    output bus_pkg::narrow_fwd_t  out_fwd,
    input  logic                  out_rdy
);

    localparam int unsigned NW = $bits(bus_pkg::narrow_t);

    // ==============================
    // State
    // ==============================
    // Wide word being split
    logic             full_v;
    bus_pkg::wide_t   wide_d;
    // 0 while the first half is on the output, 1 for the second
    logic             sel;

    bus_pkg::narrow_t first_half;
    bus_pkg::narrow_t second_half;
    logic             in_acc;
    logic             out_acc;
    logic             last;

    // Half order matches the upsizer
    assign first_half  = BIGENDIAN ? wide_d[2*NW-1:NW] : wide_d[NW-1:0];
    assign second_half = BIGENDIAN ? wide_d[NW-1:0] : wide_d[2*NW-1:NW];

    // ==============================
    // Handshake
    // ==============================
    assign out_acc = full_v && out_rdy;
    // Second half leaves, register frees up this cycle
    assign last    = out_acc && sel;
    assign in_rdy  = !full_v || last;
    assign in_acc  = in_fwd.valid && in_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_v <= 1'b0;
            sel    <= 1'b0;
        end else begin
            if (in_acc) begin
                full_v <= 1'b1;
            end else if (last) begin
                full_v <= 1'b0;
            end
            // Back to 0 after the second half, ready for the next word
            if (out_acc) begin
                sel <= !sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_acc) begin
            wide_d <= in_fwd.data;
        end
    end

    assign out_fwd = '{valid: full_v, data: (sel ? second_half : first_half)};

endmodule

`default_nettype wire

/* src/bus_chain_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bus_params.svh"

module bus_chain_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  bus_pkg::narrow_fwd_t  in_fwd,
    output logic                  in_rdy,
    output bus_pkg::narrow_fwd_t  out_fwd,
    input  logic                  out_rdy
);

    // ==============================
    // Wide links
    // ==============================
    // Upsizer to pipe
    bus_pkg::wide_fwd_t up_fwd;
    logic               up_rdy;
    // Pipe to downsizer
    bus_pkg::wide_fwd_t pipe_fwd;
    logic               pipe_rdy;

    // ==============================
    // Narrow to wide
    // ==============================
    bus_width_up #(
        .BIGENDIAN (`BUS_BIGENDIAN)
    ) u_bus_width_up (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_fwd  (in_fwd),
        .in_rdy  (in_rdy),
        .out_fwd (up_fwd),
        .out_rdy (up_rdy)
    );

    // Registered stages, rdy broken at every stage
    bus_pipe #(
        .STAGES (`BUS_PIPE_STAGES)
    ) u_bus_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_fwd  (up_fwd),
        .in_rdy  (up_rdy),
        .out_fwd (pipe_fwd),
        .out_rdy (pipe_rdy)
    );

    // ==============================
    // Wide to narrow
    // ==============================
    // Same BIGENDIAN as the upsizer keeps port order unchanged
    bus_width_down #(
        .BIGENDIAN (`BUS_BIGENDIAN)
    ) u_bus_width_down (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_fwd  (pipe_fwd),
        .in_rdy  (pipe_rdy),
        .out_fwd (out_fwd),
        .out_rdy (out_rdy)
    );

endmodule

`default_nettype wire

/* tb/bus_chain_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_chain_asserts (
    input  logic                  clk,
    input  logic                  arst_n,
    input  bus_pkg::narrow_fwd_t  in_fwd,
    input  logic                  in_rdy,
    input  bus_pkg::narrow_fwd_t  out_fwd,
    input  logic                  out_rdy
);

    logic        in_acc;
    logic        out_acc;
    // Words taken in with valid high and not yet delivered
    logic [15:0] in_flight;

    assign in_acc  = in_fwd.valid && in_rdy;
    assign out_acc = out_fwd.valid && out_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= '0;
        end else begin
            case ({in_acc, out_acc})
                2'b10:   in_flight <= in_flight + 16'd1;
                2'b01:   in_flight <= in_flight - 16'd1;
                default: ;
            endcase
        end
    end

    // ==============================
    // Handshake rules
    // ==============================
    // Stalled output word stays put
    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_fwd.valid && !out_rdy |=> out_fwd.valid && $stable(out_fwd.data))
        else $error("out_fwd changed while out_rdy was low");

    // Nothing leaves during reset
    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !out_fwd.valid)
        else $error("out_fwd.valid high during reset");

    // Every output needs an input taken with valid high
    a_no_phantom: assert property (@(posedge clk) disable iff (!arst_n)
        out_acc |-> in_flight != 16'd0)
        else $error("output transfer with no valid input word in flight");

endmodule

bind bus_chain_top bus_chain_asserts u_bus_chain_asserts (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_fwd  (in_fwd),
    .in_rdy  (in_rdy),
    .out_fwd (out_fwd),
    .out_rdy (out_rdy)
);

`default_nettype wire

/* tb/bus_chain_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bus_params.svh"

module bus_chain_tb;

    localparam int unsigned CLK_NS      = 8;
    localparam int unsigned STAGES      = `BUS_PIPE_STAGES;
    // Narrow words over all streaming tests
    localparam int unsigned TOTAL_WORDS = 2 * (1 + 200 + 200 + 200 + 300);
    // Output rdy low half the time roughly halves the rate
    localparam int unsigned STALL_FACTOR = 4;
    localparam int unsigned WATCHDOG_NS  = TOTAL_WORDS * STALL_FACTOR * CLK_NS + 4000;
    localparam int unsigned DRAIN_CYCLES = 2 * STAGES + 8;

    logic                 clk;
    logic                 arst_n;
    bus_pkg::narrow_fwd_t in_fwd;
    logic                 in_rdy;
    bus_pkg::narrow_fwd_t out_fwd;
    logic                 out_rdy;

    // Reference model, words in acceptance order
    bus_pkg::narrow_t model_q [$];
    logic [31:0]      lfsr;
    string            cur_test;
    int unsigned      err_cnt;
    int unsigned      test_cnt;
    int unsigned      words_checked;
    // Per-stream results
    int unsigned      gap_cnt;
    int unsigned      pair_in_cyc;
    int unsigned      out0_cyc;
    int unsigned      out1_cyc;

    bus_chain_top u_bus_chain_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_fwd  (in_fwd),
        .in_rdy  (in_rdy),
        .out_fwd (out_fwd),
        .out_rdy (out_rdy)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // ==============================
    // Random source
    // ==============================
    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int unsigned n, output logic [31:0] val);
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // ==============================
    // Checks
    // ==============================
    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("error: t=%0t %s expected %b got %b", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_out(input bus_pkg::narrow_t got);
        bus_pkg::narrow_t exp;
        if (model_q.size() == 0) begin
            $display("test %s: output word %h arrived with the model queue empty",
                cur_test, got);
            err_cnt++;
        end else begin
            exp = model_q.pop_front();
            words_checked++;
            if (got !== exp) begin
                $display("error: t=%0t out_fwd.data expected %h got %h", $time, exp, got);
                err_cnt++;
            end
        end
    endtask

    task automatic end_test(input int unsigned err_before, input int unsigned words);
        test_cnt++;
        $display("test %s: %0d words, %0d errors", cur_test, words, err_cnt - err_before);
    endtask

    // ==============================
    // Stream driver and monitor
    // ==============================
    task automatic run_stream(input int unsigned pairs, input bit in_stall,
                              input bit out_stall);
        int unsigned total;
        int unsigned sent;
        int unsigned got;
        int unsigned cyc;
        logic [31:0] r;
        bit          pending;
        bit          started;
        total   = 2 * pairs;
        sent    = 0;
        got     = 0;
        cyc     = 0;
        pending = 1'b0;
        started = 1'b0;
        gap_cnt = 0;
        while (sent < total || got < total) begin
            @(negedge clk);
            // Offered word stays until taken
            if (!pending) begin
                in_fwd.valid = 1'b0;
                if (sent < total) begin
                    r = 32'd1;
                    // Gap on one cycle in four
                    if (in_stall) begin
                        random_bits(2, r);
                    end
                    if (r != 32'd0) begin
                        random_bits(32, r);
                        in_fwd.valid = 1'b1;
                        in_fwd.data  = r;
                        pending      = 1'b1;
                    end
                end
            end
            if (out_stall) begin
                random_bits(1, r);
                out_rdy = r[0];
            end else begin
                out_rdy = 1'b1;
            end
            @(posedge clk);
            cyc++;
            if (in_fwd.valid && in_rdy) begin
                model_q.push_back(in_fwd.data);
                if (sent == 1) begin
                    pair_in_cyc = cyc;
                end
                sent++;
                pending = 1'b0;
            end
            if (out_fwd.valid && out_rdy) begin
                check_out(out_fwd.data);
                if (got == 0) begin
                    out0_cyc = cyc;
                end
                if (got == 1) begin
                    out1_cyc = cyc;
                end
                got++;
                started = 1'b1;
            end else if (started && got < total) begin
                gap_cnt++;
            end
        end
        drain_check(sent, got);
    endtask

    // Idle inputs, nothing more may come out
    task automatic drain_check(input int unsigned sent, input int unsigned got);
        int unsigned extra;
        extra = 0;
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            in_fwd.valid = 1'b0;
            out_rdy      = 1'b1;
            @(posedge clk);
            if (out_fwd.valid) begin
                check_out(out_fwd.data);
                extra++;
            end
        end
        if (got + extra != sent) begin
            $display("test %s: %0d words came out but %0d went in",
                cur_test, got + extra, sent);
            err_cnt++;
        end
        if (model_q.size() != 0) begin
            $display("test %s: %0d words never came out", cur_test, model_q.size());
            err_cnt++;
        end
    endtask

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    // ==============================
    // Tests
    // ==============================
    initial begin
        int unsigned err_before;
        lfsr          = 32'd83;
        err_cnt       = 0;
        test_cnt      = 0;
        words_checked = 0;
        arst_n        = 1'b0;
        in_fwd        = '0;
        out_rdy       = 1'b1;

        cur_test   = "reset_state";
        err_before = err_cnt;
        repeat (8) begin
            @(negedge clk);
            check_bit("out_fwd.valid", 1'b0, out_fwd.valid);
            check_bit("in_rdy", 1'b1, in_rdy);
        end
        arst_n = 1'b1;
        @(posedge clk);
        check_bit("out_fwd.valid", 1'b0, out_fwd.valid);
        check_bit("in_rdy", 1'b1, in_rdy);
        end_test(err_before, 0);

        // First word due STAGES + 2 edges after the second is taken
        cur_test   = "pair_latency";
        err_before = err_cnt;
        run_stream(1, 1'b0, 1'b0);
        if (out0_cyc != pair_in_cyc + STAGES + 2) begin
            $display("error: t=%0t first output latency expected %0d got %0d",
                $time, STAGES + 2, out0_cyc - pair_in_cyc);
            err_cnt++;
        end
        if (out1_cyc != out0_cyc + 1) begin
            $display("error: t=%0t second output gap expected %0d got %0d",
                $time, 1, out1_cyc - out0_cyc);
            err_cnt++;
        end
        end_test(err_before, 2);

        cur_test   = "full_rate";
        err_before = err_cnt;
        run_stream(200, 1'b0, 1'b0);
        if (gap_cnt != 0) begin
            $display("test %s: output went idle on %0d cycles mid stream", cur_test, gap_cnt);
            err_cnt++;
        end
        end_test(err_before, 400);

        cur_test   = "input_stalls";
        err_before = err_cnt;
        run_stream(200, 1'b1, 1'b0);
        end_test(err_before, 400);

        cur_test   = "back_pressure";
        err_before = err_cnt;
        run_stream(200, 1'b0, 1'b1);
        end_test(err_before, 400);

        cur_test   = "random_both";
        err_before = err_cnt;
        run_stream(300, 1'b1, 1'b1);
        end_test(err_before, 600);

        $display("tests %0d, words checked %0d, errors %0d", test_cnt, words_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/bus_pkg.sv
src/bus_width_up.sv
src/bus_pipe.sv
src/bus_width_down.sv
src/bus_chain_top.sv
tb/bus_chain_asserts.sv
tb/bus_chain_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the bus chain testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module bus_chain_tb -f compile.f -o bus_chain_sim \
    && ./obj_dir/bus_chain_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
